// ==== Makefile ====
# Verilator flow for the data cache testbench
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/dcache_access_stage.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_access_stage (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                s1_valid,
    input  wire logic                s1_write,
    input  wire logic                s1_hit,
    input  wire dcache_pkg::way_t    s1_way,
    input  wire dcache_pkg::index_t  s1_index,
    input  wire dcache_pkg::offset_t s1_offset,
    input  wire dcache_pkg::size_e   s1_size,
    input  wire dcache_pkg::word_t   s1_wdata,
    input  wire dcache_pkg::line_t   ram0_rdata,
    input  wire dcache_pkg::line_t   ram1_rdata,
    input  wire logic                wb_line_valid,
    input  wire dcache_pkg::way_t    wb_way,
    input  wire dcache_pkg::way_t    tag_victim_way,
    input  wire dcache_pkg::addr_t   tag_victim_addr,
    input  wire logic                tag_victim_dirty,
    output logic                     rsp_valid,
    output logic                     rsp_hit,
    output dcache_pkg::word_t        rsp_rdata,
    output dcache_pkg::way_t         victim_way,
    output dcache_pkg::addr_t        victim_addr,
    output logic                     victim_dirty,
    output logic                     commit_valid,
    output dcache_pkg::way_t         commit_way,
    output dcache_pkg::index_t       commit_index,
    output dcache_pkg::line_t        commit_line,
    output dcache_pkg::line_t        wb_line
);

    dcache_pkg::line_t hit_line;
    dcache_pkg::word_t new_word;
    dcache_pkg::word_t lane_data; // store data replicated across lanes
    dcache_pkg::be_t   be;
    dcache_pkg::way_t  wb_way_q;
    logic [`DCACHE_OFFSET_W-3:0] word_sel;

    assign word_sel = s1_offset[`DCACHE_OFFSET_W-1:2];
    assign hit_line = s1_way ? ram1_rdata : ram0_rdata;

    assign rsp_valid = s1_valid;
    assign rsp_hit   = s1_hit;
    assign rsp_rdata = hit_line[word_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W];

    // misaligned or bad size gives an empty mask
    always_comb begin
        be        = '0;
        lane_data = s1_wdata;
        case (s1_size)
            dcache_pkg::SIZE_BYTE: begin
                be        = dcache_pkg::be_t'(4'b0001 << s1_offset[1:0]);
                lane_data = {4{s1_wdata[7:0]}};
            end
            dcache_pkg::SIZE_HALF: begin
                if (!s1_offset[0]) begin
                    be = dcache_pkg::be_t'(4'b0011 << s1_offset[1:0]);
                end
                lane_data = {2{s1_wdata[15:0]}};
            end
            dcache_pkg::SIZE_WORD: begin
                if (s1_offset[1:0] == 2'b00) begin
                    be = '1;
                end
            end
            default: be = '0;
        endcase
    end

    always_comb begin
        new_word = rsp_rdata;
        for (int i = 0; i < $bits(dcache_pkg::be_t); i++) begin
            if (be[i]) begin
                new_word[8*i +: 8] = lane_data[8*i +: 8];
            end
        end
        commit_line = hit_line;
        commit_line[word_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W] = new_word;
    end

    assign commit_valid = s1_valid && s1_write && s1_hit;
    assign commit_way   = s1_way;
    assign commit_index = s1_index;

    // sampled every cycle, valid with rsp_valid
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            victim_way   <= 1'b0;
            victim_dirty <= 1'b0;
        end else begin
            victim_way   <= tag_victim_way;
            victim_dirty <= tag_victim_dirty;
        end
    end

    always_ff @(posedge clk) begin
        victim_addr <= tag_victim_addr;
        wb_way_q    <= wb_way; // ram data lands a cycle later
    end

    assign wb_line = wb_line_valid ? (wb_way_q ? ram1_rdata : ram0_rdata) : '0;

endmodule

`default_nettype wire

// ==== hdl/dcache_line_ram.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_line_ram (
    input  wire logic               clk,
    input  wire dcache_pkg::index_t addr,
    input  wire logic               we,
    input  wire dcache_pkg::line_t  wdata,
    output dcache_pkg::line_t       rdata
);

    dcache_pkg::line_t mem [`DCACHE_SETS];

    // read-first single port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_lookup_stage.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_lookup_stage (
    input  wire logic                clk,
    input  wire logic                rst,
    // request
    input  wire logic                req_valid,
    input  wire logic                req_write,
    input  wire dcache_pkg::addr_t   req_addr,
    input  wire dcache_pkg::size_e   req_size,
    input  wire dcache_pkg::word_t   req_wdata,
    output logic                     req_ready,
    // fill and write-back
    input  wire logic                fill_valid,
    input  wire dcache_pkg::way_t    fill_way,
    input  wire dcache_pkg::addr_t   fill_addr,
    input  wire dcache_pkg::line_t   fill_line,
    input  wire logic                wb_valid,
    input  wire dcache_pkg::way_t    wb_way,
    input  wire dcache_pkg::addr_t   wb_addr,
    // tag array
    input  wire logic                hit_way0,
    input  wire logic                hit_way1,
    // store commit from stage 2
    input  wire logic                commit_valid,
    input  wire dcache_pkg::way_t    commit_way,
    input  wire dcache_pkg::index_t  commit_index,
    input  wire dcache_pkg::line_t   commit_line,
    output dcache_pkg::index_t       lookup_index,
    output dcache_pkg::tag_t         lookup_tag,
    output logic                     lookup_fire,
    // line rams
    output dcache_pkg::index_t       ram0_addr,
    output logic                     ram0_we,
    output dcache_pkg::index_t       ram1_addr,
    output logic                     ram1_we,
    output dcache_pkg::line_t        ram_wdata,
    // stage register
    output logic                     s1_valid,
    output logic                     s1_write,
    output logic                     s1_hit,
    output dcache_pkg::way_t         s1_way,
    output dcache_pkg::index_t       s1_index,
    output dcache_pkg::offset_t      s1_offset,
    output dcache_pkg::size_e        s1_size,
    output dcache_pkg::word_t        s1_wdata,
    output logic                     wb_line_valid
);

    dcache_pkg::index_t ram_addr;
    logic               fill_grant;
    logic               wb_grant;

    assign lookup_index = req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign lookup_tag   = req_addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W+`DCACHE_INDEX_W];

    // ram port busy with commit, fill or write-back
    assign req_ready   = !(commit_valid || fill_valid || wb_valid);
    assign lookup_fire = req_valid && req_ready;

    assign fill_grant = fill_valid && !commit_valid;
    assign wb_grant   = wb_valid && !commit_valid && !fill_valid;

    // commit > fill > write-back read > lookup read
    always_comb begin
        if (commit_valid) begin
            ram_addr = commit_index;
        end else if (fill_valid) begin
            ram_addr = fill_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        end else if (wb_valid) begin
            ram_addr = wb_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        end else begin
            ram_addr = lookup_index;
        end
    end

    assign ram0_addr = ram_addr;
    assign ram1_addr = ram_addr;
    assign ram0_we   = (commit_valid && !commit_way) || (fill_grant && !fill_way);
    assign ram1_we   = (commit_valid && commit_way) || (fill_grant && fill_way);
    assign ram_wdata = commit_valid ? commit_line : fill_line;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid      <= 1'b0;
            wb_line_valid <= 1'b0;
        end else begin
            s1_valid      <= lookup_fire;
            wb_line_valid <= wb_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_fire) begin
            s1_write  <= req_write;
            s1_hit    <= hit_way0 || hit_way1;
            s1_way    <= hit_way1;
            s1_index  <= lookup_index;
            s1_offset <= req_addr[`DCACHE_OFFSET_W-1:0];
            s1_size   <= req_size;
            s1_wdata  <= req_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_pkg.sv ====
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;

    // tag is what remains above index and offset
    typedef logic [`DCACHE_ADDR_W-`DCACHE_INDEX_W-`DCACHE_OFFSET_W-1:0] tag_t;

    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [8*(1<<`DCACHE_OFFSET_W)-1:0] line_t;

    typedef logic [`DCACHE_WORD_W/8-1:0] be_t; // one bit per byte lane

    typedef logic way_t;

    // access size, 3 is not a legal encoding
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

endpackage

`default_nettype wire

// ==== hdl/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address width of the core
`define DCACHE_ADDR_W 32

// 256 sets, two ways each
`define DCACHE_INDEX_W 8

// 16-byte lines
`define DCACHE_OFFSET_W 4

// data word seen by the core
`define DCACHE_WORD_W 32

// must match DCACHE_INDEX_W
`define DCACHE_SETS 256

`endif

// ==== hdl/dcache_tag_array.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_tag_array (
    input  wire logic                clk,
    input  wire logic                rst,
    // lookup
    input  wire dcache_pkg::index_t  lookup_index,
    input  wire dcache_pkg::tag_t    lookup_tag,
    input  wire logic                lookup_fire,
    output logic                     hit_way0,
    output logic                     hit_way1,
    output dcache_pkg::way_t         victim_way,
    output dcache_pkg::addr_t        victim_addr,
    output logic                     victim_dirty,
    // line fill
    input  wire logic                fill_valid,
    input  wire dcache_pkg::way_t    fill_way,
    input  wire dcache_pkg::addr_t   fill_addr,
    // store commit
    input  wire logic                commit_valid,
    input  wire dcache_pkg::way_t    commit_way,
    input  wire dcache_pkg::index_t  commit_index,
    // write-back
    input  wire logic                wb_valid,
    input  wire dcache_pkg::way_t    wb_way,
    input  wire dcache_pkg::addr_t   wb_addr
);

    logic [`DCACHE_SETS-1:0] valid [2];
    logic [`DCACHE_SETS-1:0] dirty [2];
    logic [`DCACHE_SETS-1:0] lru; // way to evict next
    dcache_pkg::tag_t        tags [2][`DCACHE_SETS];

    dcache_pkg::index_t fill_index;
    dcache_pkg::tag_t   fill_tag;
    dcache_pkg::index_t wb_index;
    logic               victim_valid;

    assign fill_index = fill_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign fill_tag   = fill_addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W+`DCACHE_INDEX_W];
    assign wb_index   = wb_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    assign hit_way0 = valid[0][lookup_index] && (tags[0][lookup_index] == lookup_tag);
    assign hit_way1 = valid[1][lookup_index] && (tags[1][lookup_index] == lookup_tag);

    // empty ways first, then lru
    always_comb begin
        if (!valid[0][lookup_index]) begin
            victim_way = 1'b0;
        end else if (!valid[1][lookup_index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[lookup_index];
        end
    end

    assign victim_valid = valid[victim_way][lookup_index];

    // an empty way reports the line being looked up
    assign victim_addr  = {victim_valid ? tags[victim_way][lookup_index] : lookup_tag,
                           lookup_index, dcache_pkg::offset_t'(0)};
    assign victim_dirty = dirty[victim_way][lookup_index];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '{default: '0};
            dirty <= '{default: '0};
            lru   <= '0;
        end else begin
            if (lookup_fire && (hit_way0 || hit_way1)) begin
                lru[lookup_index] <= hit_way0; // the other way ages
            end
            if (fill_valid) begin
                valid[fill_way][fill_index] <= 1'b1;
                dirty[fill_way][fill_index] <= 1'b0; // fresh from memory
                lru[fill_index]             <= ~fill_way;
            end
            if (commit_valid) begin
                dirty[commit_way][commit_index] <= 1'b1;
            end
            if (wb_valid) begin
                dirty[wb_way][wb_index] <= 1'b0;
            end
        end
    end

    // tag storage, qualified by valid
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tags[fill_way][fill_index] <= fill_tag;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`default_nettype none

module dcache_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req_valid,
    input  wire logic                req_write,
    input  wire dcache_pkg::addr_t   req_addr,
    input  wire dcache_pkg::size_e   req_size,
    input  wire dcache_pkg::word_t   req_wdata,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output logic                     rsp_hit,
    output dcache_pkg::word_t        rsp_rdata,
    output dcache_pkg::way_t         victim_way,
    output dcache_pkg::addr_t        victim_addr,
    output logic                     victim_dirty,
    input  wire logic                fill_valid,
    input  wire dcache_pkg::way_t    fill_way,
    input  wire dcache_pkg::addr_t   fill_addr,
    input  wire dcache_pkg::line_t   fill_line,
    input  wire logic                wb_valid,
    input  wire dcache_pkg::way_t    wb_way,
    input  wire dcache_pkg::addr_t   wb_addr,
    output dcache_pkg::line_t        wb_line,
    output logic                     wb_line_valid
);

    logic                hit_way0;
    logic                hit_way1;
    dcache_pkg::index_t  lookup_index;
    dcache_pkg::tag_t    lookup_tag;
    logic                lookup_fire;
    dcache_pkg::way_t    tag_victim_way;
    dcache_pkg::addr_t   tag_victim_addr;
    logic                tag_victim_dirty;
    dcache_pkg::index_t  ram0_addr;
    dcache_pkg::index_t  ram1_addr;
    logic                ram0_we;
    logic                ram1_we;
    dcache_pkg::line_t   ram_wdata;
    dcache_pkg::line_t   ram0_rdata;
    dcache_pkg::line_t   ram1_rdata;
    logic                s1_valid;
    logic                s1_write;
    logic                s1_hit;
    dcache_pkg::way_t    s1_way;
    dcache_pkg::index_t  s1_index;
    dcache_pkg::offset_t s1_offset;
    dcache_pkg::size_e   s1_size;
    dcache_pkg::word_t   s1_wdata;
    logic                commit_valid;
    dcache_pkg::way_t    commit_way;
    dcache_pkg::index_t  commit_index;
    dcache_pkg::line_t   commit_line;

    dcache_tag_array tag_array (
        .clk, .rst,
        .lookup_index, .lookup_tag, .lookup_fire,
        .hit_way0, .hit_way1,
        .victim_way   (tag_victim_way),
        .victim_addr  (tag_victim_addr),
        .victim_dirty (tag_victim_dirty),
        .fill_valid, .fill_way, .fill_addr,
        .commit_valid, .commit_way, .commit_index,
        .wb_valid, .wb_way, .wb_addr
    );

    dcache_line_ram way0_ram (
        .clk, .addr (ram0_addr), .we (ram0_we), .wdata (ram_wdata), .rdata (ram0_rdata)
    );

    dcache_line_ram way1_ram (
        .clk, .addr (ram1_addr), .we (ram1_we), .wdata (ram_wdata), .rdata (ram1_rdata)
    );

    dcache_lookup_stage lookup_stage (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_size, .req_wdata, .req_ready,
        .fill_valid, .fill_way, .fill_addr, .fill_line,
        .wb_valid, .wb_way, .wb_addr,
        .hit_way0, .hit_way1,
        .commit_valid, .commit_way, .commit_index, .commit_line,
        .lookup_index, .lookup_tag, .lookup_fire,
        .ram0_addr, .ram0_we, .ram1_addr, .ram1_we, .ram_wdata,
        .s1_valid, .s1_write, .s1_hit, .s1_way, .s1_index, .s1_offset, .s1_size, .s1_wdata,
        .wb_line_valid
    );

    dcache_access_stage access_stage (
        .clk, .rst,
        .s1_valid, .s1_write, .s1_hit, .s1_way, .s1_index, .s1_offset, .s1_size, .s1_wdata,
        .ram0_rdata, .ram1_rdata,
        .wb_line_valid, .wb_way,
        .tag_victim_way, .tag_victim_addr, .tag_victim_dirty,
        .rsp_valid, .rsp_hit, .rsp_rdata,
        .victim_way, .victim_addr, .victim_dirty,
        .commit_valid, .commit_way, .commit_index, .commit_line,
        .wb_line
    );

endmodule

`default_nettype wire

// ==== sim/dcache_tb_tasks.svh ====
`ifndef DCACHE_TB_TASKS_SVH
`define DCACHE_TB_TASKS_SVH

// 32-bit lcg step
function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

function automatic dcache_pkg::line_t random_line();
    dcache_pkg::line_t l;
    for (int i = 0; i < 4; i++) begin
        l[`DCACHE_WORD_W*i +: `DCACHE_WORD_W] = next_rand();
    end
    return l;
endfunction

function automatic dcache_pkg::index_t index_of(input dcache_pkg::addr_t addr);
    return addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
endfunction

function automatic dcache_pkg::tag_t tag_of(input dcache_pkg::addr_t addr);
    return addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W+`DCACHE_INDEX_W];
endfunction

// expected word after a store, bad size or alignment keeps the old word
function automatic dcache_pkg::word_t merge_word(input dcache_pkg::word_t old,
        input dcache_pkg::word_t wdata, input dcache_pkg::size_e size,
        input dcache_pkg::offset_t off);
    dcache_pkg::word_t mask;
    dcache_pkg::word_t data;
    int                sh;
    sh = 8 * int'(off[1:0]);
    case (size)
        dcache_pkg::SIZE_BYTE: begin
            mask = 32'h0000_00ff << sh;
            data = dcache_pkg::word_t'(wdata[7:0]) << sh;
        end
        dcache_pkg::SIZE_HALF: begin
            if (off[0]) return old;
            mask = 32'h0000_ffff << sh;
            data = dcache_pkg::word_t'(wdata[15:0]) << sh;
        end
        dcache_pkg::SIZE_WORD: begin
            if (off[1:0] != 2'b00) return old;
            mask = '1;
            data = wdata;
        end
        default: return old;
    endcase
    return (old & ~mask) | (data & mask);
endfunction

task automatic check_word(input string name, input dcache_pkg::word_t got,
        input dcache_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_line(input string name, input dcache_pkg::line_t got,
        input dcache_pkg::line_t exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_addr(input string name, input dcache_pkg::addr_t got,
        input dcache_pkg::addr_t exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic report_timeout(input string what);
    failure_count++;
    $display("ERROR at %0t: gave up waiting for %s", $time, what);
    finish_run();
endtask

task automatic wait_ready();
    int n;
    n = 0;
    @(negedge clk);
    while (!req_ready) begin
        n++;
        if (n >= timeout_cycles) report_timeout("req_ready");
        @(negedge clk);
    end
endtask

task automatic wait_rsp();
    int n;
    n = 0;
    @(negedge clk);
    while (!rsp_valid) begin
        n++;
        if (n >= timeout_cycles) report_timeout("rsp_valid");
        @(negedge clk);
    end
endtask

task automatic drive_req(input logic write, input dcache_pkg::addr_t addr,
        input dcache_pkg::size_e size, input dcache_pkg::word_t wdata);
    req_valid <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_size  <= size;
    req_wdata <= wdata;
endtask

// checks the response seen now and updates the model
task automatic expect_rsp(input logic write, input dcache_pkg::addr_t addr,
        input dcache_pkg::size_e size, input dcache_pkg::word_t wdata);
    dcache_pkg::index_t  idx;
    dcache_pkg::offset_t off;
    logic                hit0;
    logic                hit1;
    dcache_pkg::way_t    way;
    dcache_pkg::way_t    v;
    dcache_pkg::word_t   old_w;
    int                  ws;
    idx  = index_of(addr);
    off  = addr[`DCACHE_OFFSET_W-1:0];
    ws   = int'(off[`DCACHE_OFFSET_W-1:2]);
    hit0 = m_valid[0][idx] && (m_tag[0][idx] == tag_of(addr));
    hit1 = m_valid[1][idx] && (m_tag[1][idx] == tag_of(addr));
    check_bit("rsp_hit", rsp_hit, hit0 || hit1);
    if (hit0 || hit1) begin
        way        = hit1;
        old_w      = m_line[way][idx][`DCACHE_WORD_W*ws +: `DCACHE_WORD_W];
        m_lru[idx] = !way;
        if (write) begin
            check_bit("req_ready", req_ready, 1'b0); // commit cycle
            m_line[way][idx][`DCACHE_WORD_W*ws +: `DCACHE_WORD_W] =
                merge_word(old_w, wdata, size, off);
            m_dirty[way][idx] = 1'b1;
        end else begin
            check_word("rsp_rdata", rsp_rdata, old_w);
        end
    end else begin
        if (!m_valid[0][idx]) begin
            v = 1'b0;
        end else if (!m_valid[1][idx]) begin
            v = 1'b1;
        end else begin
            v = m_lru[idx];
        end
        check_bit("victim_way", victim_way, v);
        check_bit("victim_dirty", victim_dirty, m_dirty[v][idx]);
        if (m_valid[v][idx]) begin
            check_addr("victim_addr", victim_addr, {m_tag[v][idx], idx, 4'h0});
        end else begin
            // empty way gives the requested line
            check_addr("victim_addr", victim_addr, addr & line_mask);
        end
    end
endtask

task automatic access(input logic write, input dcache_pkg::addr_t addr,
        input dcache_pkg::size_e size, input dcache_pkg::word_t wdata);
    @(posedge clk);
    drive_req(write, addr, size, wdata);
    wait_ready();
    @(posedge clk);
    req_valid <= 1'b0;
    wait_rsp();
    expect_rsp(write, addr, size, wdata);
endtask

// four loads, one accepted per cycle
task automatic load_burst(input dcache_pkg::addr_t base);
    dcache_pkg::addr_t a [4];
    for (int i = 0; i < 4; i++) begin
        a[i] = base + dcache_pkg::addr_t'(4 * i);
    end
    @(posedge clk);
    drive_req(1'b0, a[0], dcache_pkg::SIZE_WORD, '0);
    wait_ready();
    for (int i = 0; i < 4; i++) begin
        @(posedge clk);
        if (i < 3) begin
            drive_req(1'b0, a[i+1], dcache_pkg::SIZE_WORD, '0);
        end else begin
            req_valid <= 1'b0;
        end
        @(negedge clk);
        check_bit("rsp_valid", rsp_valid, 1'b1);
        check_bit("req_ready", req_ready, 1'b1);
        expect_rsp(1'b0, a[i], dcache_pkg::SIZE_WORD, '0);
    end
endtask

task automatic refill(input dcache_pkg::way_t way, input dcache_pkg::addr_t addr);
    dcache_pkg::line_t  line;
    dcache_pkg::index_t idx;
    line = random_line();
    idx  = index_of(addr);
    @(posedge clk);
    fill_valid <= 1'b1;
    fill_way   <= way;
    fill_addr  <= addr;
    fill_line  <= line;
    @(negedge clk);
    check_bit("req_ready", req_ready, 1'b0);
    @(posedge clk);
    fill_valid <= 1'b0;
    m_line[way][idx]  = line;
    m_tag[way][idx]   = tag_of(addr);
    m_valid[way][idx] = 1'b1;
    m_dirty[way][idx] = 1'b0;
    m_lru[idx]        = !way;
endtask

task automatic write_back(input dcache_pkg::way_t way, input dcache_pkg::addr_t addr);
    dcache_pkg::index_t idx;
    int                 n;
    idx = index_of(addr);
    n   = 0;
    @(posedge clk);
    wb_valid <= 1'b1;
    wb_way   <= way;
    wb_addr  <= addr;
    @(negedge clk);
    check_bit("req_ready", req_ready, 1'b0);
    @(posedge clk);
    wb_valid <= 1'b0;
    @(negedge clk);
    while (!wb_line_valid) begin
        n++;
        if (n >= timeout_cycles) report_timeout("wb_line_valid");
        @(negedge clk);
    end
    check_line("wb_line", wb_line, m_line[way][idx]);
    m_dirty[way][idx] = 1'b0;
endtask

task automatic after_reset_misses();
    @(negedge clk);
    check_bit("req_ready", req_ready, 1'b1);
    repeat (6) begin
        access(1'b0, next_rand(), dcache_pkg::SIZE_WORD, '0);
    end
endtask

task automatic fill_and_load_hits();
    for (int w = 0; w < 2; w++) begin
        line_base[w] = next_rand() & line_mask;
        refill(dcache_pkg::way_t'(w), line_base[w]);
        load_burst(line_base[w]);
    end
endtask

// sizes include the invalid encoding, offsets include misaligned ones
task automatic store_merges();
    dcache_pkg::addr_t a;
    logic [31:0]       r;
    for (int n = 0; n < 16; n++) begin
        r = next_rand();
        a = line_base[n % 2] | dcache_pkg::addr_t'(r[3:0]);
        access(1'b1, a, dcache_pkg::size_e'(r[5:4]), next_rand());
        access(1'b0, a, dcache_pkg::SIZE_WORD, '0);
    end
endtask

task automatic replacement_victim();
    repl_addr[0] = next_rand() & line_mask;
    repl_addr[1] = repl_addr[0] + tag_step;
    repl_addr[2] = repl_addr[0] + (tag_step << 1);
    refill(1'b0, repl_addr[0]);
    refill(1'b1, repl_addr[1]);
    access(1'b1, repl_addr[1] | dcache_pkg::addr_t'(8), dcache_pkg::SIZE_WORD, next_rand());
    access(1'b0, repl_addr[0], dcache_pkg::SIZE_WORD, '0); // way 0 most recent
    access(1'b0, repl_addr[2], dcache_pkg::SIZE_WORD, '0); // miss evicts dirty way 1
endtask

task automatic writeback_clears_dirty();
    write_back(1'b1, repl_addr[1]);
    access(1'b0, repl_addr[2], dcache_pkg::SIZE_WORD, '0);
    access(1'b1, line_base[0], dcache_pkg::SIZE_WORD, next_rand());
    write_back(1'b0, line_base[0]);
endtask

`endif

// ==== sim/dcache_tb.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;

    localparam int timeout_cycles = 50;
    localparam dcache_pkg::addr_t line_mask = ~dcache_pkg::addr_t'((1 << `DCACHE_OFFSET_W) - 1);
    localparam dcache_pkg::addr_t tag_step =
        dcache_pkg::addr_t'(1 << (`DCACHE_INDEX_W + `DCACHE_OFFSET_W));

    logic               clk;
    logic               rst;
    logic               req_valid;
    logic               req_write;
    dcache_pkg::addr_t  req_addr;
    dcache_pkg::size_e  req_size;
    dcache_pkg::word_t  req_wdata;
    logic               req_ready;
    logic               rsp_valid;
    logic               rsp_hit;
    dcache_pkg::word_t  rsp_rdata;
    dcache_pkg::way_t   victim_way;
    dcache_pkg::addr_t  victim_addr;
    logic               victim_dirty;
    logic               fill_valid;
    dcache_pkg::way_t   fill_way;
    dcache_pkg::addr_t  fill_addr;
    dcache_pkg::line_t  fill_line;
    logic               wb_valid;
    dcache_pkg::way_t   wb_way;
    dcache_pkg::addr_t  wb_addr;
    dcache_pkg::line_t  wb_line;
    logic               wb_line_valid;

    // shadow copy of the cache state
    dcache_pkg::line_t  m_line  [2][`DCACHE_SETS];
    dcache_pkg::tag_t   m_tag   [2][`DCACHE_SETS];
    logic               m_valid [2][`DCACHE_SETS];
    logic               m_dirty [2][`DCACHE_SETS];
    logic               m_lru   [`DCACHE_SETS]; // way to evict next

    logic [31:0]        rng_state;
    int                 check_count;
    int                 mismatch_count;
    int                 failure_count;
    dcache_pkg::addr_t  line_base [2]; // one line per way for the store tests
    dcache_pkg::addr_t  repl_addr [3]; // three tags in one set

    dcache_top dcache_top_inst (.*);

    `include "dcache_tb_tasks.svh"

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rng_state      = 32'ha57c;
        check_count    = 0;
        mismatch_count = 0;
        failure_count  = 0;
        req_valid      = 1'b0;
        req_write      = 1'b0;
        req_addr       = '0;
        req_size       = dcache_pkg::SIZE_WORD;
        req_wdata      = '0;
        fill_valid     = 1'b0;
        fill_way       = 1'b0;
        fill_addr      = '0;
        fill_line      = '0;
        wb_valid       = 1'b0;
        wb_way         = 1'b0;
        wb_addr        = '0;
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_dirty[0][s] = 1'b0;
            m_dirty[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        rst = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;

        after_reset_misses();
        fill_and_load_hits();
        store_merges();
        replacement_victim();
        writeback_clears_dirty();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
+incdir+sim
hdl/dcache_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_line_ram.sv
hdl/dcache_lookup_stage.sv
hdl/dcache_access_stage.sv
hdl/dcache_top.sv
sim/dcache_tb.sv
